/* rv32_defs.svh */
`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

// Major opcodes that the front end cares about.
`define RV32_OPCODE_JAL     7'b1101111
`define RV32_OPCODE_BRANCH  7'b1100011

// addi x0, x0, 0 is the canonical RV32 no-op.
`define RV32_INSTR_NOP      32'h0000_0013

// Instruction memory word address width.
// 8 bits give 256 words, so byte pcs wrap every 1024 bytes.
`define RV32_IMEM_AW        8

// Number of entries held between fetch and the branch resolver.
`define RV32_FQ_DEPTH       4

`endif

/* rv32_frontend_pkg.sv */
`default_nettype none

package rv32_frontend_pkg;

    // J-type layout, as seen by a JAL.
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jal_fmt_t;

    // B-type layout, as seen by a conditional branch.
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } branch_fmt_t;

    // One instruction word with both decodings laid over it.
    // The opcode and the immediate sign sit in the same bits in either view.
    typedef union packed {
        jal_fmt_t    jal_fmt;
        branch_fmt_t branch_fmt;
    } rv32_instr_u;

    // What fetch hands down the pipe for every fetched word.
    typedef struct packed {
        logic [31:0] pc;
        rv32_instr_u instr;
        logic        predicted_taken;
    } fetch_entry_t;

    // A retired instruction as it leaves the front end.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } retire_t;

endpackage

`default_nettype wire

/* rv32_instr_mem.sv */
`default_nettype none

`include "rv32_defs.svh"

module rv32_instr_mem (
    input  logic                     clk,

    // program load port
    input  logic                     prog_write,
    input  logic [`RV32_IMEM_AW-1:0] prog_addr,
    input  logic [31:0]              prog_data,

    // fetch port, byte addressed
    input  logic [31:0]              read_addr,
    output logic [31:0]              read_data
);

    logic [31:0] mem [0:(1 << `RV32_IMEM_AW)-1];

    always_ff @(posedge clk) begin
        if (prog_write) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // The low two bits select a byte within the word and are ignored.
    // Bits above the word address are dropped, so the address space wraps.
    assign read_data = mem[read_addr[`RV32_IMEM_AW+1:2]];

endmodule

`default_nettype wire

/* rv32_fetch.sv */
`default_nettype none

`include "rv32_defs.svh"

module rv32_fetch (
    input  logic                           clk,
    input  logic                           reset_,

    // control from the top level and the resolver
    input  logic                           stall,
    input  logic                           mispredict,
    input  logic [31:0]                    branch_pc,

    // instruction memory
    input  logic [31:0]                    instr_read_value,
    output logic [31:0]                    instr_address,

    // towards the fetch queue
    output logic                           fetch_valid,
    output rv32_frontend_pkg::fetch_entry_t fetch_entry
);

    logic [31:0] next_pc;
    logic [31:0] pc_raw;
    logic [31:0] pc;

    rv32_frontend_pkg::rv32_instr_u fetched;

    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic        predicted_taken;
    logic [31:0] pc_offset;

    // A redirect from the resolver overrides the predicted path.
    assign pc_raw = mispredict ? branch_pc : next_pc;

    // Keep only the bits the memory decodes, so the pc wraps with it.
    assign pc = {{(30 - `RV32_IMEM_AW){1'b0}}, pc_raw[`RV32_IMEM_AW+1:0]};

    assign instr_address = pc;
    assign fetched = instr_read_value;

    assign imm_j = {{12{fetched.jal_fmt.imm_20}},
                    fetched.jal_fmt.imm_19_12,
                    fetched.jal_fmt.imm_11,
                    fetched.jal_fmt.imm_10_1,
                    1'b0};

    assign imm_b = {{20{fetched.branch_fmt.imm_12}},
                    fetched.branch_fmt.imm_11,
                    fetched.branch_fmt.imm_10_5,
                    fetched.branch_fmt.imm_4_1,
                    1'b0};

    // Static prediction.
    // Jumps are always taken and backward branches are assumed to be loops.
    always_comb begin
        predicted_taken = 1'b0;
        pc_offset = 32'd4;
        if (fetched.jal_fmt.opcode == `RV32_OPCODE_JAL) begin
            predicted_taken = 1'b1;
            pc_offset = imm_j;
        end else if (fetched.branch_fmt.opcode == `RV32_OPCODE_BRANCH &&
                     fetched.branch_fmt.imm_12) begin
            predicted_taken = 1'b1;
            pc_offset = imm_b;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            next_pc <= 32'd0;
            fetch_valid <= 1'b0;
            fetch_entry.pc <= 32'd0;
            fetch_entry.instr <= `RV32_INSTR_NOP;
            fetch_entry.predicted_taken <= 1'b0;
        end else if (!stall) begin
            next_pc <= pc + pc_offset;
            fetch_valid <= 1'b1;
            fetch_entry.pc <= pc;
            fetch_entry.instr <= fetched;
            fetch_entry.predicted_taken <= predicted_taken;
        end
    end

endmodule

`default_nettype wire

/* rv32_fetch_queue.sv */
`default_nettype none

`include "rv32_defs.svh"

module rv32_fetch_queue (
    input  logic                            clk,
    input  logic                            reset_,

    input  logic                            write,
    input  rv32_frontend_pkg::fetch_entry_t write_entry,

    input  logic                            pop,
    input  logic                            flush,

    output rv32_frontend_pkg::fetch_entry_t head,
    output logic                            not_empty,
    output logic                            full
);

    localparam int PTR_W = $clog2(`RV32_FQ_DEPTH);

    rv32_frontend_pkg::fetch_entry_t entries [0:`RV32_FQ_DEPTH-1];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;

    logic do_write;
    logic do_pop;

    // Pointers wrap explicitly so the depth need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`RV32_FQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // A flush wins over everything, including the entry arriving with it.
    assign do_write = write && !flush;
    assign do_pop = pop && not_empty && !flush;

    assign head = entries[rd_ptr];
    assign not_empty = (count != '0);
    assign full = (count == (PTR_W+1)'(`RV32_FQ_DEPTH));

    always_ff @(posedge clk) begin
        if (do_write) begin
            entries[wr_ptr] <= write_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_ || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rv32_branch_resolver.sv */
`default_nettype none

`include "rv32_defs.svh"

module rv32_branch_resolver (
    input  logic                            clk,
    input  logic                            reset_,

    input  logic                            retire_ready,

    // fetch queue head
    input  logic                            not_empty,
    input  rv32_frontend_pkg::fetch_entry_t head,

    // register file load port
    input  logic                            reg_write,
    input  logic [4:0]                      reg_addr,
    input  logic [31:0]                     reg_data,

    output logic                            pop,
    output logic                            mispredict,
    output logic [31:0]                     branch_pc,

    output logic                            retire_valid,
    output rv32_frontend_pkg::retire_t      retire,
    output logic [15:0]                     mispredict_count
);

    logic [31:0] regs [0:31];

    rv32_frontend_pkg::rv32_instr_u instr;

    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic        cond_taken;
    logic        actual_taken;
    logic [31:0] taken_offset;

    always_ff @(posedge clk) begin
        if (reg_write) begin
            regs[reg_addr] <= reg_data;
        end
    end

    assign instr = head.instr;

    // x0 is hardwired to zero whatever was written there.
    assign rs1_val = (instr.branch_fmt.rs1 == 5'd0) ? 32'd0 : regs[instr.branch_fmt.rs1];
    assign rs2_val = (instr.branch_fmt.rs2 == 5'd0) ? 32'd0 : regs[instr.branch_fmt.rs2];

    assign imm_j = {{12{instr.jal_fmt.imm_20}}, instr.jal_fmt.imm_19_12,
                    instr.jal_fmt.imm_11, instr.jal_fmt.imm_10_1, 1'b0};
    assign imm_b = {{20{instr.branch_fmt.imm_12}}, instr.branch_fmt.imm_11,
                    instr.branch_fmt.imm_10_5, instr.branch_fmt.imm_4_1, 1'b0};

    always_comb begin
        case (instr.branch_fmt.funct3)
            3'd0: cond_taken = (rs1_val == rs2_val);
            3'd1: cond_taken = (rs1_val != rs2_val);
            3'd4: cond_taken = ($signed(rs1_val) < $signed(rs2_val));
            3'd5: cond_taken = ($signed(rs1_val) >= $signed(rs2_val));
            3'd6: cond_taken = (rs1_val < rs2_val);
            3'd7: cond_taken = (rs1_val >= rs2_val);
            // funct3 values 2 and 3 are not branches and fall through.
            default: cond_taken = 1'b0;
        endcase
    end

    // JAL is resolved as well, although fetch should always get it right.
    always_comb begin
        actual_taken = 1'b0;
        taken_offset = imm_b;
        if (instr.jal_fmt.opcode == `RV32_OPCODE_JAL) begin
            actual_taken = 1'b1;
            taken_offset = imm_j;
        end else if (instr.branch_fmt.opcode == `RV32_OPCODE_BRANCH) begin
            actual_taken = cond_taken;
        end
    end

    assign pop = not_empty && retire_ready;
    assign mispredict = pop && (actual_taken != head.predicted_taken);
    assign branch_pc = head.pc + (actual_taken ? taken_offset : 32'd4);

    always_ff @(posedge clk) begin
        if (!reset_) begin
            retire_valid <= 1'b0;
            mispredict_count <= 16'd0;
        end else begin
            retire_valid <= pop;
            if (mispredict) begin
                mispredict_count <= mispredict_count + 16'd1;
            end
        end
    end

    // Retire payload only changes when something is popped.
    always_ff @(posedge clk) begin
        if (!reset_) begin
            retire.pc <= 32'd0;
            retire.instr <= `RV32_INSTR_NOP;
        end else if (pop) begin
            retire.pc <= head.pc;
            retire.instr <= head.instr;
        end
    end

endmodule

`default_nettype wire

/* rv32_frontend.sv */
`default_nettype none

`include "rv32_defs.svh"

module rv32_frontend (
    input  logic                       clk,
    input  logic                       reset_,

    input  logic                       run,

    input  logic                       prog_write,
    input  logic [`RV32_IMEM_AW-1:0]   prog_addr,
    input  logic [31:0]                prog_data,

    input  logic                       reg_write,
    input  logic [4:0]                 reg_addr,
    input  logic [31:0]                reg_data,

    input  logic                       retire_ready,

    output logic                       retire_valid,
    output rv32_frontend_pkg::retire_t retire,
    output logic [15:0]                mispredict_count
);

    logic [31:0] instr_address;
    logic [31:0] instr_read_value;

    logic                            fetch_valid;
    rv32_frontend_pkg::fetch_entry_t fetch_entry;

    logic                            queue_write;
    logic                            not_empty;
    logic                            full;
    rv32_frontend_pkg::fetch_entry_t head;

    logic        stall;
    logic        pop;
    logic        mispredict;
    logic [31:0] branch_pc;

    // A redirect must always be taken, even when the queue is full or run is low.
    assign stall = (full || !run) && !mispredict;
    assign queue_write = fetch_valid && !stall;

    rv32_instr_mem imem0 (
        .clk        (clk),
        .prog_write (prog_write),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .read_addr  (instr_address),
        .read_data  (instr_read_value)
    );

    rv32_fetch fetch0 (
        .clk              (clk),
        .reset_           (reset_),
        .stall            (stall),
        .mispredict       (mispredict),
        .branch_pc        (branch_pc),
        .instr_read_value (instr_read_value),
        .instr_address    (instr_address),
        .fetch_valid      (fetch_valid),
        .fetch_entry      (fetch_entry)
    );

    rv32_fetch_queue fq0 (
        .clk         (clk),
        .reset_      (reset_),
        .write       (queue_write),
        .write_entry (fetch_entry),
        .pop         (pop),
        .flush       (mispredict),
        .head        (head),
        .not_empty   (not_empty),
        .full        (full)
    );

    rv32_branch_resolver resolver0 (
        .clk              (clk),
        .reset_           (reset_),
        .retire_ready     (retire_ready),
        .not_empty        (not_empty),
        .head             (head),
        .reg_write        (reg_write),
        .reg_addr         (reg_addr),
        .reg_data         (reg_data),
        .pop              (pop),
        .mispredict       (mispredict),
        .branch_pc        (branch_pc),
        .retire_valid     (retire_valid),
        .retire           (retire),
        .mispredict_count (mispredict_count)
    );

endmodule

`default_nettype wire

/* rv32_frontend_properties.sv */
`default_nettype none

`include "rv32_defs.svh"

module rv32_frontend_properties (
    input logic                            clk,
    input logic                            reset_,
    input logic                            stall,
    input logic                            fetch_valid,
    input rv32_frontend_pkg::fetch_entry_t fetch_entry,
    input logic                            queue_write,
    input logic                            full,
    input logic                            pop,
    input logic                            mispredict,
    input logic                            retire_valid
);

    int occupancy;

    // Shadow of the queue fill level, rebuilt from the write, pop and flush strobes.
    always_ff @(posedge clk) begin
        if (!reset_ || mispredict) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + (queue_write ? 1 : 0) - (pop ? 1 : 0);
        end
    end

    hold_while_stalled: assert property (@(posedge clk) disable iff (!reset_)
        stall |=> $stable(fetch_entry) && $stable(fetch_valid))
        else $error("fetch entry changed while stalled");

    // the redirecting branch is popped and retires one cycle later.
    mispredict_needs_pop: assert property (@(posedge clk) disable iff (!reset_)
        mispredict |-> pop ##1 retire_valid)
        else $error("mispredict without a pop");

    retire_quiet_after_reset: assert property (@(posedge clk)
        !reset_ |=> !retire_valid)
        else $error("retire_valid high right after reset");

    no_write_when_full: assert property (@(posedge clk) disable iff (!reset_)
        queue_write && (occupancy == `RV32_FQ_DEPTH) |-> mispredict)
        else $error("queue written while full");

    occupancy_in_range: assert property (@(posedge clk) disable iff (!reset_)
        occupancy <= `RV32_FQ_DEPTH && full == (occupancy == `RV32_FQ_DEPTH))
        else $error("queue fill level out of range");

endmodule

bind rv32_frontend rv32_frontend_properties props0 (
    .clk          (clk),
    .reset_       (reset_),
    .stall        (stall),
    .fetch_valid  (fetch_valid),
    .fetch_entry  (fetch_entry),
    .queue_write  (queue_write),
    .full         (full),
    .pop          (pop),
    .mispredict   (mispredict),
    .retire_valid (retire_valid)
);

`default_nettype wire

/* tb_rv32_frontend.sv */
`default_nettype none

`include "rv32_defs.svh"

module tb_rv32_frontend;

    localparam int NUM_WORDS = 1 << `RV32_IMEM_AW;
    localparam int NUM_RETIRE = 400;
    localparam int RESET_AT = 250;
    localparam int LOAD_CYCLES = NUM_WORDS + 31 + 16;
    localparam int WATCHDOG_TIME = (LOAD_CYCLES + NUM_RETIRE * 40) * 10;
    localparam logic [31:0] PC_MASK = NUM_WORDS * 4 - 1;

    logic                       clk;
    logic                       reset_;
    logic                       run;
    logic                       prog_write;
    logic [`RV32_IMEM_AW-1:0]   prog_addr;
    logic [31:0]                prog_data;
    logic                       reg_write;
    logic [4:0]                 reg_addr;
    logic [31:0]                reg_data;
    logic                       retire_ready;
    logic                       retire_valid;
    rv32_frontend_pkg::retire_t retire;
    logic [15:0]                mispredict_count;

    logic [31:0] mem_model [0:NUM_WORDS-1];
    logic [31:0] reg_model [0:31];
    logic [31:0] model_pc;
    logic [15:0] model_count;
    int          retired;

    rv32_frontend dut0 (
        .clk              (clk),
        .reset_           (reset_),
        .run              (run),
        .prog_write       (prog_write),
        .prog_addr        (prog_addr),
        .prog_data        (prog_data),
        .reg_write        (reg_write),
        .reg_addr         (reg_addr),
        .reg_data         (reg_data),
        .retire_ready     (retire_ready),
        .retire_valid     (retire_valid),
        .retire           (retire),
        .mispredict_count (mispredict_count)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // J-type and B-type encodings with rd fixed to x1 for jumps.
    function automatic logic [31:0] encode_jal(input logic [31:0] offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], 5'd1, `RV32_OPCODE_JAL};
    endfunction

    function automatic logic [31:0] encode_branch(input logic [2:0] funct3,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
                `RV32_OPCODE_BRANCH};
    endfunction

    // Half ALU words, the rest split between jumps and branches, offsets of +-1..8 words.
    task automatic load_program();
        int          i;
        int          kind;
        int          words;
        logic [31:0] rnd;
        logic [31:0] offset;
        logic [31:0] word;
        for (i = 0; i < NUM_WORDS; i++) begin
            kind = int'($urandom % 10);
            words = int'($urandom % 16) - 8;
            rnd = $urandom;
            if (words >= 0) begin
                words = words + 1;
            end
            offset = words * 4;
            if (kind < 5) begin
                word = {rnd[31:7], 7'b0010011};
            end else if (kind < 7) begin
                word = encode_jal(offset);
            end else begin
                word = encode_branch(rnd[15:13], rnd[7:3], rnd[12:8], offset);
            end
            @(negedge clk);
            prog_write = 1'b1;
            prog_addr = i[`RV32_IMEM_AW-1:0];
            prog_data = word;
            mem_model[i] = word;
        end
        @(negedge clk);
        prog_write = 1'b0;
    endtask

    // few distinct values so that equal and signed or unsigned ordering all show up.
    task automatic load_registers();
        int          i;
        logic [31:0] value;
        reg_model[0] = 32'd0;
        for (i = 1; i < 32; i++) begin
            case ($urandom % 4)
                0: value = 32'd0;
                1: value = 32'd1;
                2: value = 32'hFFFF_FFFF;
                default: value = 32'h8000_0000;
            endcase
            @(negedge clk);
            reg_write = 1'b1;
            reg_addr = i[4:0];
            reg_data = value;
            reg_model[i] = value;
        end
        @(negedge clk);
        reg_write = 1'b0;
    endtask

    // advances the architectural pc by one instruction and counts wrong static guesses.
    task automatic model_step();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] offset;
        logic        taken;
        w = mem_model[model_pc[`RV32_IMEM_AW+1:2]];
        a = reg_model[w[19:15]];
        b = reg_model[w[24:20]];
        offset = 32'd4;
        if (w[6:0] == `RV32_OPCODE_JAL) begin
            offset = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end else if (w[6:0] == `RV32_OPCODE_BRANCH) begin
            case (w[14:12])
                3'd0: taken = (a == b);
                3'd1: taken = (a != b);
                3'd4: taken = ($signed(a) < $signed(b));
                3'd5: taken = ($signed(a) >= $signed(b));
                3'd6: taken = (a < b);
                3'd7: taken = (a >= b);
                default: taken = 1'b0;
            endcase
            if (taken) begin
                offset = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            if (taken != w[31]) begin
                model_count = model_count + 16'd1;
            end
        end
        model_pc = (model_pc + offset) & PC_MASK;
    endtask

    task automatic reset_mid_run();
        reset_ = 1'b0;
        repeat (4) @(negedge clk);
        reset_ = 1'b1;
        model_pc = 32'd0;
        model_count = 16'd0;
        check_value("count after reset", 32'd0, {16'd0, mispredict_count});
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Error: timeout, retirement stalled after %0d instructions", retired);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset_ = 1'b0;
        run = 1'b0;
        prog_write = 1'b0;
        prog_addr = '0;
        prog_data = 32'd0;
        reg_write = 1'b0;
        reg_addr = 5'd0;
        reg_data = 32'd0;
        retire_ready = 1'b0;
        retired = 0;
        model_pc = 32'd0;
        model_count = 16'd0;
        void'($urandom(32'ha371_45b1));
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_ = 1'b1;
        load_program();
        load_registers();
        run = 1'b1;
        while (retired < NUM_RETIRE) begin
            @(negedge clk);
            if (retire_valid) begin
                check_value("retire pc", model_pc, retire.pc);
                check_value("retire instr", mem_model[model_pc[`RV32_IMEM_AW+1:2]],
                            retire.instr);
                model_step();
                check_value("mispredict count", {16'd0, model_count}, {16'd0, mispredict_count});
                retired++;
                if (retired == RESET_AT) begin
                    reset_mid_run();
                end
            end
            retire_ready = ($urandom % 3) != 0;
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
rv32_frontend_pkg.sv
rv32_instr_mem.sv
rv32_fetch.sv
rv32_fetch_queue.sv
rv32_branch_resolver.sv
rv32_frontend.sv
rv32_frontend_properties.sv
tb_rv32_frontend.sv
